// File: files.f
+incdir+src
+incdir+verif
src/egr_pkg.sv
src/egr_beat_if.sv
src/egr_port_demux.sv
src/egr_port_buffer.sv
src/egr_width_conv.sv
src/egr_router_egress.sv
verif/egr_tb.sv

// File: Bender.yml
package:
  name: egr_router_egress

sources:
  - include_dirs:
      - src
    files:
      - src/egr_pkg.sv
      - src/egr_beat_if.sv
      - src/egr_port_demux.sv
      - src/egr_port_buffer.sv
      - src/egr_width_conv.sv
      - src/egr_router_egress.sv
  - target: test
    include_dirs:
      - src
      - verif
    files:
      - verif/egr_tb.sv

// File: verif/egr_tb_util.svh
/* Helpers included inside egr_tb: LFSR, compare tasks and model state.
   Relies on the `EGR_* constants being defined before the include */

`ifndef EGR_TB_UTIL_SVH
`define EGR_TB_UTIL_SVH

// Expected bytes per port, with a flag on the final byte of each packet
logic [7:0] exp_bytes   [`EGR_NUM_PORTS][$];
bit         exp_eop     [`EGR_NUM_PORTS][$];
int         pkt_beats   [`EGR_NUM_PORTS][$];
int         outstanding [`EGR_NUM_PORTS];
int         ovf_exp     [`EGR_NUM_PORTS];
int         ovf_seen    [`EGR_NUM_PORTS];
int         pkts_out    [`EGR_NUM_PORTS];
int         err_data;
int         err_frame;
int         err_ovf;
int         err_other;
logic [15:0] lfsr_q = 16'd89;

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        v      = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
endfunction

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp);
        err_data++;
    end
endtask

task automatic check_keep(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s got 0x%01h expected 0x%01h", name, got, exp);
        err_frame++;
    end
endtask

task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s got 0x%01h expected 0x%01h", name, got, exp);
        err_frame++;
    end
endtask

task automatic check_overflow(input int p, input int got, input int exp);
    if (got != exp) begin
        $display("CHECK FAILED overflow[%0d] pulses got 0x%0h expected 0x%0h", p, got, exp);
        err_ovf++;
    end
endtask

task automatic check_low(input string name, input logic got);
    if (got !== 1'b0) begin
        $display("CHECK FAILED %s got 0x%01h expected 0x0", name, got);
        err_other++;
    end
endtask

`endif

// File: verif/egr_tb.sv
/* Random-traffic testbench for the egress stage, fixed LFSR seed.
   Sink ready is random except while port 2 is held stalled */

`timescale 1ns/10ps
`default_nettype none

`include "egr_settings.svh"

module egr_tb;

    import egr_pkg::*;

    localparam int NN         = `EGR_NUM_NARROW_PORTS;
    localparam int NW         = `EGR_NUM_PORTS - `EGR_NUM_NARROW_PORTS;
    localparam int CLK_PERIOD = 4;
    localparam int MAX_GAP    = 7;
    localparam int N_RAND     = 200;
    localparam int N_HOLD     = 4;
    // Random, framing, port 2 drop with side traffic, recovery
    localparam int N_PKTS     = N_RAND + 5 * `EGR_NUM_PORTS + 4 * N_HOLD + 20;

    logic                       clk_ifc = 1'b0;
    logic                       arst_n;
    logic [`EGR_IN_BYTES*8-1:0] in_data;
    logic [`EGR_IN_BYTES-1:0]   in_keep;
    logic                       in_last;
    logic                       in_valid;
    port_idx_t                  in_port;
    logic [7:0]                 out8_data   [NN];
    logic                       out8_valid  [NN];
    logic                       out8_last   [NN];
    logic                       out8_ready  [NN];
    logic [31:0]                out32_data  [NW];
    logic [3:0]                 out32_keep  [NW];
    logic                       out32_valid [NW];
    logic                       out32_last  [NW];
    logic                       out32_ready [NW];
    logic [`EGR_NUM_PORTS-1:0]  overflow;

    logic                       stall2;
    bit                         stall_q   [`EGR_NUM_PORTS];
    logic [31:0]                held_data [`EGR_NUM_PORTS];
    logic                       held_last [`EGR_NUM_PORTS];

    egr_router_egress dut_i (.*);

    `include "egr_tb_util.svh"

    always #(CLK_PERIOD / 2) clk_ifc = ~clk_ifc;

    function automatic string sig_name(input int p, input string field);
        return (p < NN) ? $sformatf("out8_%s[%0d]", field, p)
                        : $sformatf("out32_%s[%0d]", field, p - NN);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    // Advance to the next falling edge; sink ready is redrawn here
    task automatic next_cycle();
        @(negedge clk_ifc);
        in_valid = 1'b0;
        for (int n = 0; n < NN; n++) begin
            out8_ready[n] = (rand_bits(2) != 0);
        end
        for (int w = 0; w < NW; w++) begin
            out32_ready[w] = (rand_bits(2) != 0) && !(stall2 && (NN + w == 2));
        end
    endtask

    task automatic send_packet(input int p, input int len, input logic [7:0] start);
        int beats;
        int idx;
        beats = (len + 7) / 8;
        // Store only if the packet fits beside everything not yet delivered
        if (outstanding[p] + beats > `EGR_BUF_WORDS) begin
            ovf_exp[p]++;
        end else begin
            outstanding[p] += beats;
            pkt_beats[p].push_back(beats);
            for (int k = 0; k < len; k++) begin
                exp_bytes[p].push_back(8'(start + k));
                exp_eop[p].push_back(k == len - 1);
            end
        end
        for (int b = 0; b < beats; b++) begin
            next_cycle();
            in_data = '0;
            in_keep = '0;
            for (int j = 0; j < `EGR_IN_BYTES; j++) begin
                idx = b * `EGR_IN_BYTES + j;
                if (idx < len) begin
                    in_data[j*8 +: 8] = 8'(start + idx);
                    in_keep[j]        = 1'b1;
                end
            end
            in_last  = (b == beats - 1);
            in_port  = port_idx_t'(p);
            in_valid = 1'b1;
        end
    endtask

    // Keep the port at most half full so random traffic is never dropped
    task automatic random_packet(input int p, input int len);
        int n;
        n = 0;
        while (outstanding[p] > `EGR_BUF_WORDS / 2 && n < 20000) begin
            next_cycle();
            n++;
        end
        if (n == 20000) begin
            $display("port %0d never drained below half full", p);
            err_other++;
        end
        send_packet(p, len, 8'(rand_bits(8)));
        repeat (rand_bits(3)) next_cycle();
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((outstanding.sum() != 0) && n < 100000) begin
            next_cycle();
            n++;
        end
        if (n == 100000) begin
            $display("output ports did not drain all expected packets");
            err_other++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sinks

    task automatic take_word(input int p, input logic [31:0] data, input logic [3:0] keep,
                             input logic last, input int width);
        int         n;
        bit         eop;
        logic [7:0] b;
        n   = 0;
        eop = 1'b0;
        while (n < width && !eop) begin
            if (exp_bytes[p].size() == 0) begin
                $display("port %0d delivered a byte that was never sent", p);
                err_other++;
                return;
            end
            b   = exp_bytes[p].pop_front();
            eop = exp_eop[p].pop_front();
            check_byte(sig_name(p, "data"), data[n*8 +: 8], b);
            n++;
        end
        if (width > 1) begin
            check_keep(sig_name(p, "keep"), keep, 4'((1 << n) - 1));
        end
        check_last(sig_name(p, "last"), last, eop);
        if (eop) begin
            outstanding[p] -= pkt_beats[p].pop_front();
            pkts_out[p]++;
        end
    endtask

    // A stalled word must stay valid and unchanged until it is taken
    task automatic watch_hold(input int p, input logic valid, input logic ready,
                              input logic [31:0] data, input logic last);
        if (stall_q[p] && !valid) begin
            $display("%s dropped while its sink held ready low", sig_name(p, "valid"));
            err_other++;
        end else if (stall_q[p]) begin
            for (int i = 0; i < 4; i++) begin
                check_byte(sig_name(p, "data"), data[i*8 +: 8], held_data[p][i*8 +: 8]);
            end
            check_last(sig_name(p, "last"), last, held_last[p]);
        end
        stall_q[p]   = valid && !ready;
        held_data[p] = data;
        held_last[p] = last;
    endtask

    always @(posedge clk_ifc) begin
        if (arst_n) begin
            for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
                if (overflow[p]) begin
                    ovf_seen[p]++;
                end
            end
            for (int n = 0; n < NN; n++) begin
                watch_hold(n, out8_valid[n], out8_ready[n], {24'h0, out8_data[n]}, out8_last[n]);
                if (out8_valid[n] && out8_ready[n]) begin
                    take_word(n, {24'h0, out8_data[n]}, 4'h1, out8_last[n], 1);
                end
            end
            for (int w = 0; w < NW; w++) begin
                watch_hold(NN + w, out32_valid[w], out32_ready[w], out32_data[w], out32_last[w]);
                if (out32_valid[w] && out32_ready[w]) begin
                    take_word(NN + w, out32_data[w], out32_keep[w], out32_last[w], 4);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and report

    initial begin
        int p;
        int len;
        int frame_len [5] = '{1, 4, 7, 8, 9};
        arst_n   = 1'b0;
        in_data  = '0;
        in_keep  = '0;
        in_last  = 1'b0;
        in_valid = 1'b0;
        in_port  = '0;
        stall2   = 1'b0;
        out8_ready  = '{default: 1'b0};
        out32_ready = '{default: 1'b0};
        repeat (3) @(negedge clk_ifc);
        arst_n = 1'b1;
        for (int n = 0; n < NN; n++) check_low(sig_name(n, "valid"), out8_valid[n]);
        for (int w = 0; w < NW; w++) check_low(sig_name(NN + w, "valid"), out32_valid[w]);
        for (int q = 0; q < `EGR_NUM_PORTS; q++) check_low($sformatf("overflow[%0d]", q), overflow[q]);

        repeat (N_RAND) begin
            p   = rand_bits(2);
            len = 1 + rand_bits(8);
            random_packet(p, len);
        end
        // Short packets around the beat and word boundaries
        for (int q = 0; q < `EGR_NUM_PORTS; q++) begin
            foreach (frame_len[i]) random_packet(q, frame_len[i]);
        end
        wait_drain();

        // Port 2 stalled: two full-size packets fit, the rest are dropped
        stall2 = 1'b1;
        for (int i = 0; i < N_HOLD; i++) begin
            send_packet(2, `EGR_MAX_PKT_BYTES, 8'(rand_bits(8)));
            repeat (3) begin
                p   = (rand_bits(2) == 2) ? 3 : rand_bits(2) % 2;
                len = 1 + rand_bits(8);
                random_packet(p, len);
            end
        end
        repeat (4) next_cycle();
        for (int q = 0; q < `EGR_NUM_PORTS; q++) check_overflow(q, ovf_seen[q], ovf_exp[q]);
        stall2 = 1'b0;
        wait_drain();

        for (int i = 0; i < 20; i++) random_packet(i % `EGR_NUM_PORTS, 1 + rand_bits(8));
        wait_drain();

        for (int q = 0; q < `EGR_NUM_PORTS; q++) begin
            check_overflow(q, ovf_seen[q], ovf_exp[q]);
            if (pkts_out[q] == 0) begin
                $display("port %0d received no packets", q);
                err_other++;
            end
        end
        $display("errors: data %0d, framing %0d, overflow %0d, other %0d",
                 err_data, err_frame, err_ovf, err_other);
        if (err_data + err_frame + err_ovf + err_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(N_PKTS * (`EGR_MAX_PKT_BYTES + MAX_GAP) * 4 * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/egr_router_egress.sv
/* Egress stage top. The input cannot be stalled; overflow[p] pulses once
   for each packet dropped at port p. Narrow ports carry no keep */

`timescale 1ns/10ps
`default_nettype none

`include "egr_settings.svh"

module egr_router_egress (
    input  wire logic                       clk_ifc,
    input  wire logic                       arst_n,

    // Input stream
    input  wire logic [`EGR_IN_BYTES*8-1:0] in_data,
    input  wire logic [`EGR_IN_BYTES-1:0]   in_keep,
    input  wire logic                       in_last,
    input  wire logic                       in_valid,
    input  wire egr_pkg::port_idx_t         in_port,

    // 8-bit ports
    output logic [7:0]  out8_data  [`EGR_NUM_NARROW_PORTS],
    output logic        out8_valid [`EGR_NUM_NARROW_PORTS],
    output logic        out8_last  [`EGR_NUM_NARROW_PORTS],
    input  wire logic   out8_ready [`EGR_NUM_NARROW_PORTS],

    // 32-bit ports
    output logic [31:0] out32_data  [`EGR_NUM_PORTS-`EGR_NUM_NARROW_PORTS],
    output logic [3:0]  out32_keep  [`EGR_NUM_PORTS-`EGR_NUM_NARROW_PORTS],
    output logic        out32_valid [`EGR_NUM_PORTS-`EGR_NUM_NARROW_PORTS],
    output logic        out32_last  [`EGR_NUM_PORTS-`EGR_NUM_NARROW_PORTS],
    input  wire logic   out32_ready [`EGR_NUM_PORTS-`EGR_NUM_NARROW_PORTS],

    output logic [`EGR_NUM_PORTS-1:0] overflow
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal links

    egr_beat_if push_link [`EGR_NUM_PORTS] ();
    egr_beat_if pop_link  [`EGR_NUM_PORTS] ();

    egr_port_demux demux_i (
        .clk_ifc  ( clk_ifc   ),
        .arst_n   ( arst_n    ),
        .in_data  ( in_data   ),
        .in_keep  ( in_keep   ),
        .in_last  ( in_last   ),
        .in_valid ( in_valid  ),
        .in_port  ( in_port   ),
        .bufs     ( push_link )
    );

    // One store-and-forward buffer per port
    for (genvar p = 0; p < `EGR_NUM_PORTS; p++) begin : g_buf
        egr_port_buffer buf_i (
            .clk_ifc  ( clk_ifc      ),
            .arst_n   ( arst_n       ),
            .push     ( push_link[p] ),
            .pop      ( pop_link[p]  ),
            .overflow ( overflow[p]  )
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Width converters

    for (genvar n = 0; n < `EGR_NUM_NARROW_PORTS; n++) begin : g_conv8
        egr_width_conv #(
            .OUT_BYTES ( 1 )
        ) conv_i (
            .clk_ifc   ( clk_ifc       ),
            .arst_n    ( arst_n        ),
            .in_beat   ( pop_link[n]   ),
            .out_data  ( out8_data[n]  ),
            .out_keep  (               ),
            .out_valid ( out8_valid[n] ),
            .out_last  ( out8_last[n]  ),
            .out_ready ( out8_ready[n] )
        );
    end

    // Wide ports follow the narrow ones in port numbering
    for (genvar w = 0; w < `EGR_NUM_PORTS - `EGR_NUM_NARROW_PORTS; w++) begin : g_conv32
        egr_width_conv #(
            .OUT_BYTES ( 4 )
        ) conv_i (
            .clk_ifc   ( clk_ifc                                ),
            .arst_n    ( arst_n                                 ),
            .in_beat   ( pop_link[`EGR_NUM_NARROW_PORTS + w]    ),
            .out_data  ( out32_data[w]                          ),
            .out_keep  ( out32_keep[w]                          ),
            .out_valid ( out32_valid[w]                         ),
            .out_last  ( out32_last[w]                          ),
            .out_ready ( out32_ready[w]                         )
        );
    end

endmodule

`default_nettype wire

// File: src/egr_width_conv.sv
/* Splits each input beat into OUT_BYTES words, lowest byte first.
   OUT_BYTES must divide EGR_IN_BYTES; lanes past the last kept byte are skipped */

`timescale 1ns/10ps
`default_nettype none

`include "egr_settings.svh"

module egr_width_conv #(
    parameter int OUT_BYTES = 4
) (
    input  wire logic                   clk_ifc,
    input  wire logic                   arst_n,
    egr_beat_if.snk                     in_beat,
    output logic [OUT_BYTES*8-1:0]      out_data,
    output logic [OUT_BYTES-1:0]        out_keep,
    output logic                        out_valid,
    output logic                        out_last,
    input  wire logic                   out_ready
);

    import egr_pkg::*;

    localparam int LANES  = `EGR_IN_BYTES / OUT_BYTES;
    localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

    beat_t             beat_q;
    logic              full_q;
    logic [LANE_W-1:0] lane_q;
    logic              last_word;
    logic              take;

    // Current word is the beat's last when no later lane holds a kept byte
    always_comb begin
        last_word = 1'b1;
        for (int l = 0; l < LANES; l++) begin
            if ((l > int'(lane_q)) && beat_q.keep[l*OUT_BYTES]) begin
                last_word = 1'b0;
            end
        end
    end

    // Next beat loads on the clock its predecessor's last word is taken
    assign in_beat.ready = !full_q || (out_ready && last_word);
    assign take          = in_beat.valid && in_beat.ready;

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
            lane_q <= '0;
        end else if (take) begin
            full_q <= 1'b1;
            lane_q <= '0;
        end else if (full_q && out_ready) begin
            if (last_word) begin
                full_q <= 1'b0;
            end else begin
                lane_q <= lane_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (take) begin
            beat_q <= in_beat.beat;
        end
    end

    assign out_valid = full_q;
    assign out_data  = beat_q.data[lane_q*OUT_BYTES*8 +: OUT_BYTES*8];
    assign out_keep  = beat_q.keep[lane_q*OUT_BYTES +: OUT_BYTES];
    assign out_last  = beat_q.last && last_word;

    a_hold_stable: assert property (@(posedge clk_ifc) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("output word changed while stalled");

endmodule

`default_nettype wire

// File: src/egr_port_buffer.sv
/* Store-and-forward buffer. Only whole packets are read out; a packet longer
   than the free space at its first beat is dropped whole and overflow pulses */

`timescale 1ns/10ps
`default_nettype none

`include "egr_settings.svh"

module egr_port_buffer (
    input  wire logic    clk_ifc,
    input  wire logic    arst_n,
    egr_beat_if.push_snk push,
    egr_beat_if.src      pop,
    output logic         overflow
);

    import egr_pkg::*;

    localparam int AW = $clog2(`EGR_BUF_WORDS);

    beat_t    mem [`EGR_BUF_WORDS];

    // Write side
    buf_ptr_t wr_ptr;
    buf_ptr_t cmt_ptr;
    buf_ptr_t room_q;
    buf_ptr_t used;
    buf_ptr_t free_words;
    buf_ptr_t room;
    logic     mid_pkt_q;
    logic     dropping_q;
    logic     fits;
    logic     wr_en;

    // Read side
    buf_ptr_t rd_ptr;
    beat_t    out_beat_q;
    logic     out_valid_q;
    logic     have_pkt;
    logic     load;

    ////////////////////////////////////////////////////////////////////////////
    // Write side

    // wr_ptr equals cmt_ptr on a first beat, so used counts stored packets
    assign used       = wr_ptr - rd_ptr;
    assign free_words = buf_ptr_t'(`EGR_BUF_WORDS) - used;

    // Room left for this packet, fixed at its first beat
    assign room  = mid_pkt_q ? room_q : free_words;
    assign fits  = !dropping_q && (room != '0);
    assign wr_en = push.valid && fits;

    always_ff @(posedge clk_ifc) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= push.beat;
        end
    end

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            cmt_ptr    <= '0;
            room_q     <= '0;
            mid_pkt_q  <= 1'b0;
            dropping_q <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (push.valid) begin
                mid_pkt_q <= !push.beat.last;
                if (fits) begin
                    wr_ptr <= wr_ptr + 1'b1;
                    room_q <= room - 1'b1;
                    // Packet complete, make it visible to the read side
                    if (push.beat.last) begin
                        cmt_ptr <= wr_ptr + 1'b1;
                    end
                end else begin
                    // Throw away whatever part of the packet was written
                    wr_ptr     <= cmt_ptr;
                    dropping_q <= !push.beat.last;
                    overflow   <= push.beat.last;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side

    // Reads stop at the committed pointer
    assign have_pkt = (rd_ptr != cmt_ptr);
    assign load     = have_pkt && (!out_valid_q || pop.ready);

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr      <= '0;
            out_valid_q <= 1'b0;
        end else if (load) begin
            rd_ptr      <= rd_ptr + 1'b1;
            out_valid_q <= 1'b1;
        end else if (pop.ready) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (load) begin
            out_beat_q <= mem[rd_ptr[AW-1:0]];
        end
    end

    assign pop.beat  = out_beat_q;
    assign pop.valid = out_valid_q;

    a_overflow_pulse: assert property (@(posedge clk_ifc) disable iff (!arst_n)
        overflow |=> !overflow)
        else $error("overflow high for more than one cycle");

endmodule

`default_nettype wire

// File: src/egr_port_demux.sv
/* Input has no ready; every beat with in_valid high is taken. The port is
   sampled on the first beat of a packet only */

`timescale 1ns/10ps
`default_nettype none

`include "egr_settings.svh"

module egr_port_demux (
    input  wire logic                       clk_ifc,
    input  wire logic                       arst_n,
    input  wire logic [`EGR_IN_BYTES*8-1:0] in_data,
    input  wire logic [`EGR_IN_BYTES-1:0]   in_keep,
    input  wire logic                       in_last,
    input  wire logic                       in_valid,
    input  wire egr_pkg::port_idx_t         in_port,
    egr_beat_if.push_src                    bufs [`EGR_NUM_PORTS]
);

    import egr_pkg::*;

    beat_t     beat_q;
    logic      valid_q;
    port_idx_t port_q;
    logic      mid_pkt_q;
    port_idx_t sel_port;

    // Hold the port of the packet in flight until its last beat
    assign sel_port = mid_pkt_q ? port_q : in_port;

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            valid_q   <= 1'b0;
            port_q    <= '0;
            mid_pkt_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
            if (in_valid) begin
                port_q    <= sel_port;
                mid_pkt_q <= !in_last;
            end
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (in_valid) begin
            beat_q.data <= in_data;
            beat_q.keep <= in_keep;
            beat_q.last <= in_last;
        end
    end

    // Same beat on every link, valid on the selected one only
    for (genvar p = 0; p < `EGR_NUM_PORTS; p++) begin : g_link
        assign bufs[p].beat  = beat_q;
        assign bufs[p].valid = valid_q && (port_q == port_idx_t'(p));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Input checks

    a_port_range: assert property (@(posedge clk_ifc) disable iff (!arst_n)
        in_valid && !mid_pkt_q |-> !$isunknown(in_port) && (int'(in_port) < `EGR_NUM_PORTS))
        else $error("in_port out of range at start of packet");

    // Contiguous from byte 0, and full except on a last beat
    a_keep_shape: assert property (@(posedge clk_ifc) disable iff (!arst_n)
        in_valid |-> in_keep[0] && ((in_keep & (in_keep + 1'b1)) == '0)
                     && (in_last || (&in_keep)))
        else $error("in_keep not contiguous or short on a non-last beat");

endmodule

`default_nettype wire

// File: src/egr_beat_if.sv
/* Beat link between internal blocks. The push modports have no ready,
   the sink of a push link must take every valid beat */

`timescale 1ns/10ps
`default_nettype none

interface egr_beat_if;

    import egr_pkg::*;

    beat_t beat;
    logic  valid;
    logic  ready;

    // Demux to buffer, no back-pressure
    modport push_src (
        output beat,
        output valid
    );

    modport push_snk (
        input beat,
        input valid
    );

    // Buffer to converter, valid/ready handshake
    modport src (
        output beat,
        output valid,
        input  ready
    );

    modport snk (
        input  beat,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// File: src/egr_pkg.sv
/* Types shared by the egress stage. Keep masks are contiguous from byte 0 */

`default_nettype none

`include "egr_settings.svh"

package egr_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Beat payload

    // One input beat; keep is all ones except possibly on the last beat
    typedef struct packed {
        logic [`EGR_IN_BYTES*8-1:0] data;
        logic [`EGR_IN_BYTES-1:0]   keep;
        logic                       last;
    } beat_t;

    ////////////////////////////////////////////////////////////////////////////
    // Index types

    // Destination port number
    typedef logic [$clog2(`EGR_NUM_PORTS)-1:0] port_idx_t;

    // Buffer address plus one wrap bit, so full and empty can be told apart
    typedef logic [$clog2(`EGR_BUF_WORDS):0] buf_ptr_t;

endpackage

`default_nettype wire

// File: src/egr_settings.svh
/* Sizing of the egress stage. A packet of EGR_MAX_PKT_BYTES must fit in
   EGR_BUF_WORDS beats, and EGR_IN_BYTES must be a multiple of every port width */

`ifndef EGR_SETTINGS_SVH
`define EGR_SETTINGS_SVH

// Bytes carried by one input beat
`define EGR_IN_BYTES 8

// Physical egress ports
`define EGR_NUM_PORTS 4

// Ports 0 .. EGR_NUM_NARROW_PORTS-1 are 8 bits wide, the rest 32 bits
`define EGR_NUM_NARROW_PORTS 2

// Depth of each store-and-forward buffer, in input beats
`define EGR_BUF_WORDS 64

// Largest legal packet (32 input beats)
`define EGR_MAX_PKT_BYTES 256

`endif
